/* Bender.yml */
package:
  name: qcontrol

sources:
  - include_dirs:
      - include
    files:
      - source/qc_pkg.sv
      - source/qc_mem_if.sv
      - source/delay_ram.sv
      - source/delay_mem_arbiter.sv
      - source/delay_line_writer.sv
      - source/qc_tap_reader.sv
      - source/qcontrol_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_qcontrol.sv

/* all.f */
+incdir+include
source/qc_pkg.sv
source/qc_mem_if.sv
source/delay_ram.sv
source/delay_mem_arbiter.sv
source/delay_line_writer.sv
source/qc_tap_reader.sv
source/qcontrol_top.sv
tb/tb_clock_gen.sv
tb/tb_qcontrol.sv

/* include/qc_settings.svh */
`ifndef QC_SETTINGS_SVH
`define QC_SETTINGS_SVH

////////////////////////////////////////
// Data path widths
////////////////////////////////////////

// Monitor input and Q-control output
`define QC_SAMPLE_W    16
// Signed loop gain
`define QC_GAIN_W      16

////////////////////////////////////////
// Delay line and scaling
////////////////////////////////////////

// log2 of delay memory depth, 8192 words
`define QC_PHASE_LEN2  13
// Input cycles per stored sample
`define QC_DECIM       4
// Lowest product bit kept in output
`define QC_OUT_SHIFT   13

`endif

/* source/delay_line_writer.sv */
`timescale 1ns/100ps

`include "qc_settings.svh"

module delay_line_writer
    import qc_pkg::*;
(
    input  logic         a_clk,
    input  logic         rst_n,
    input  sample_t      sig_in,
    qc_mem_if.requester  mem,
    output logic         sample_tick,
    output phase_addr_t  wr_ptr
);

    localparam int CNT_W = $clog2(`QC_DECIM);

    // Decimation phase
    logic [CNT_W-1:0] dec_cnt;
    // Captured sample awaiting its write slot
    sample_t          wr_sample;
    logic             wr_req;

    ////////////////////////////////////////
    // Decimation by QC_DECIM
    ////////////////////////////////////////

    // Last phase of each group is the tick
    assign sample_tick = (dec_cnt == CNT_W'(`QC_DECIM - 1));

    always_ff @(posedge a_clk)
    begin
        if (!rst_n)
        begin
            dec_cnt <= '0;
            wr_req  <= 1'b0;
            wr_ptr  <= '0;
        end
        else
        begin
            dec_cnt <= sample_tick ? '0 : dec_cnt + 1'b1;
            // Write done, step to next slot
            if (wr_req && mem.grant)
            begin
                wr_req <= 1'b0;
                wr_ptr <= wr_ptr + 1'b1;
            end
            // New sample, request a write
            if (sample_tick)
            begin
                wr_req <= 1'b1;
            end
        end
    end

    // Sample capture, payload only
    always_ff @(posedge a_clk)
    begin
        if (sample_tick)
        begin
            wr_sample <= sig_in;
        end
    end

    ////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////

    // Pointer holds until granted, so it is the write address
    assign mem.req   = wr_req;
    assign mem.we    = 1'b1;
    assign mem.addr  = wr_ptr;
    assign mem.wdata = wr_sample;

endmodule

/* source/delay_mem_arbiter.sv */
`timescale 1ns/100ps

module delay_mem_arbiter
    import qc_pkg::*;
(
    input logic          a_clk,
    input logic          rst_n,
    qc_mem_if.arbiter    wr_port,
    qc_mem_if.arbiter    rd_port,
    qc_mem_if.requester  ram_port
);

    // Reader won the previous cycle's read
    logic rd_owner;
    // Reader takes precedence
    logic rd_sel;

    assign rd_sel = rd_port.req;

    ////////////////////////////////////////
    // Fixed priority grant
    ////////////////////////////////////////

    // Reader whenever it asks
    assign rd_port.grant = rd_port.req & ram_port.grant;
    // Writer only on a free slot
    assign wr_port.grant = wr_port.req & ~rd_sel & ram_port.grant;

    ////////////////////////////////////////
    // Winner's fields to the RAM
    ////////////////////////////////////////
    assign ram_port.req   = rd_port.req | wr_port.req;
    assign ram_port.we    = rd_sel ? rd_port.we    : wr_port.we;
    assign ram_port.addr  = rd_sel ? rd_port.addr  : wr_port.addr;
    assign ram_port.wdata = rd_sel ? rd_port.wdata : wr_port.wdata;

    ////////////////////////////////////////
    // Read data return
    ////////////////////////////////////////

    // Track who owned the last granted read
    // Data comes back one cycle later
    always_ff @(posedge a_clk)
    begin
        if (!rst_n)
        begin
            rd_owner <= 1'b0;
        end
        else if (ram_port.req && ram_port.grant && !ram_port.we)
        begin
            rd_owner <= rd_sel;
        end
    end

    // Steer data to its owner, zero to the other
    assign rd_port.rdata = rd_owner ? ram_port.rdata : '0;
    assign wr_port.rdata = rd_owner ? '0 : ram_port.rdata;

endmodule

/* source/delay_ram.sv */
`timescale 1ns/100ps

`include "qc_settings.svh"

module delay_ram
    import qc_pkg::*;
(
    input logic          a_clk,
    qc_mem_if.arbiter    mem
);

    localparam int DEPTH = 1 << `QC_PHASE_LEN2;

    // Circular delay storage, no reset on contents
    sample_t ram [0:DEPTH-1];
    sample_t rdata_q;

    // Single port, always ready
    // One access per cycle, whatever is presented
    assign mem.grant = mem.req;

    ////////////////////////////////////////
    // Synchronous write, registered read
    ////////////////////////////////////////
    always_ff @(posedge a_clk)
    begin
        if (mem.req)
        begin
            if (mem.we)
            begin
                ram[mem.addr] <= mem.wdata;
            end
            else
            begin
                rdata_q <= ram[mem.addr];
            end
        end
    end

    // Read data holds until the next read
    assign mem.rdata = rdata_q;

endmodule

/* source/qc_mem_if.sv */
`timescale 1ns/100ps

interface qc_mem_if
    import qc_pkg::*;
();

    ////////////////////////////////////////
    // One requester's memory port
    ////////////////////////////////////////

    // Request, held until granted
    logic        req;
    // Accepted this cycle
    logic        grant;
    // High for write, low for read
    logic        we;
    phase_addr_t addr;
    sample_t     wdata;
    // Valid one cycle after a granted read
    sample_t     rdata;

    // Side issuing accesses
    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  grant,
        input  rdata
    );

    // Side serving accesses
    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output grant,
        output rdata
    );

endinterface

/* source/qc_pkg.sv */
`include "qc_settings.svh"

package qc_pkg;

    ////////////////////////////////////////
    // Q-control data types
    ////////////////////////////////////////

    // Monitor sample, also the stored word
    typedef logic signed [`QC_SAMPLE_W-1:0] sample_t;

    // Loop gain, two's complement
    typedef logic signed [`QC_GAIN_W-1:0] gain_t;

    // Delay memory address and write pointer
    // Wraps naturally at the memory depth
    typedef logic [`QC_PHASE_LEN2-1:0] phase_addr_t;

    // Full gain x sample product
    // 16 x 16 signed fits exactly in 32 bits
    typedef logic signed [31:0] product_t;

endpackage

/* source/qc_tap_reader.sv */
`timescale 1ns/100ps

`include "qc_settings.svh"

module qc_tap_reader
    import qc_pkg::*;
(
    input  logic         a_clk,
    input  logic         rst_n,
    input  logic         sample_tick,
    input  phase_addr_t  wr_ptr,
    input  logic         qc_enable,
    input  gain_t        qc_gain,
    input  logic [15:0]  qc_delay,
    qc_mem_if.requester  mem,
    output sample_t      qc_out,
    output logic         qc_out_valid
);

    // Top product bit kept, 27 for 16 bit samples
    localparam int OUT_MSB = `QC_OUT_SHIFT + `QC_SAMPLE_W - 2;

    // Settings captured at the current tick
    logic        en_reg;
    gain_t       gain_reg;
    phase_addr_t delay_reg;

    // Settings from the previous tick, used for this read
    logic        op_en;
    gain_t       op_gain;

    // Read request
    logic        rd_req;
    phase_addr_t rd_addr;
    // Granted read, data on rdata this cycle
    logic        data_pending;

    product_t    product;

    ////////////////////////////////////////
    // Settings and read issue
    ////////////////////////////////////////
    always_ff @(posedge a_clk)
    begin
        if (!rst_n)
        begin
            en_reg       <= 1'b0;
            delay_reg    <= '0;
            op_en        <= 1'b0;
            rd_req       <= 1'b0;
            data_pending <= 1'b0;
        end
        else
        begin
            // Granted reads return next cycle
            data_pending <= rd_req & mem.grant;
            if (rd_req && mem.grant)
            begin
                rd_req <= 1'b0;
            end
            if (sample_tick)
            begin
                // Address from the delay set one tick ago
                // Delay 0 lands on the slot about to be overwritten
                rd_addr   <= wr_ptr + delay_reg;
                rd_req    <= 1'b1;
                op_en     <= en_reg;
                en_reg    <= qc_enable;
                delay_reg <= qc_delay[`QC_PHASE_LEN2-1:0];
            end
        end
    end

    // Gain path, payload only
    always_ff @(posedge a_clk)
    begin
        if (sample_tick)
        begin
            op_gain  <= gain_reg;
            gain_reg <= qc_gain;
        end
    end

    // Read-only requester
    assign mem.req   = rd_req;
    assign mem.we    = 1'b0;
    assign mem.addr  = rd_addr;
    assign mem.wdata = '0;

    ////////////////////////////////////////
    // Gain multiply and output scaling
    ////////////////////////////////////////
    assign product = op_gain * mem.rdata;

    // Keep bits 27..13, sign from bit 27, wraps on overflow
    always_ff @(posedge a_clk)
    begin
        if (!rst_n)
        begin
            qc_out       <= '0;
            qc_out_valid <= 1'b0;
        end
        else
        begin
            qc_out_valid <= data_pending;
            if (data_pending)
            begin
                qc_out <= op_en ? {product[OUT_MSB], product[OUT_MSB:`QC_OUT_SHIFT]} : '0;
            end
        end
    end

endmodule

/* source/qcontrol_top.sv */
`timescale 1ns/100ps

module qcontrol_top
    import qc_pkg::*;
(
    input  logic         a_clk,
    input  logic         rst_n,
    // Monitor signal, one word per cycle
    input  sample_t      sig_in,
    // Level only, a sample is taken at every tick regardless
    input  logic         sig_in_valid,
    // Q-control settings, sampled at each tick
    input  logic         qc_enable,
    input  gain_t        qc_gain,
    input  logic [15:0]  qc_delay,
    // Q-control output and its one-cycle valid
    output sample_t      qc_out,
    output logic         qc_out_valid
);

    logic        sample_tick;
    phase_addr_t wr_ptr;

    ////////////////////////////////////////
    // Memory ports
    ////////////////////////////////////////

    // Writer to arbiter
    qc_mem_if wr_mem ();
    // Tap reader to arbiter
    qc_mem_if rd_mem ();
    // Arbiter to RAM
    qc_mem_if ram_mem ();

    ////////////////////////////////////////
    // Decimator and delay line writer
    ////////////////////////////////////////
    delay_line_writer u_delay_line_writer (
        .a_clk       (a_clk),
        .rst_n       (rst_n),
        .sig_in      (sig_in),
        .mem         (wr_mem.requester),
        .sample_tick (sample_tick),
        .wr_ptr      (wr_ptr)
    );

    ////////////////////////////////////////
    // Delayed tap, gain and output
    ////////////////////////////////////////
    qc_tap_reader u_qc_tap_reader (
        .a_clk        (a_clk),
        .rst_n        (rst_n),
        .sample_tick  (sample_tick),
        .wr_ptr       (wr_ptr),
        .qc_enable    (qc_enable),
        .qc_gain      (qc_gain),
        .qc_delay     (qc_delay),
        .mem          (rd_mem.requester),
        .qc_out       (qc_out),
        .qc_out_valid (qc_out_valid)
    );

    // Reader first, writer fills free slots
    delay_mem_arbiter u_delay_mem_arbiter (
        .a_clk    (a_clk),
        .rst_n    (rst_n),
        .wr_port  (wr_mem.arbiter),
        .rd_port  (rd_mem.arbiter),
        .ram_port (ram_mem.requester)
    );

    // Shared single-port delay memory
    delay_ram u_delay_ram (
        .a_clk (a_clk),
        .mem   (ram_mem.arbiter)
    );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
)
(
    output logic a_clk,
    output logic rst_n
);

    // Free-running clock, starts low
    initial
    begin
        a_clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) a_clk = ~a_clk;
        end
    end

    // Reset low for RESET_CYCLES edges, released just after an edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge a_clk);
        #5 rst_n = 1'b1;
    end

endmodule

/* tb/tb_qcontrol.sv */
`timescale 1ns/100ps

`include "qc_settings.svh"

module tb_qcontrol;

    localparam int DEPTH      = 1 << `QC_PHASE_LEN2;
    localparam int HIST_LEN   = 16384;
    localparam int PULSE_WAIT = 20;
    localparam int RESET_WAIT = 40;
    localparam int NUM_ROWS   = 11;
    localparam logic [31:0] SEED = 32'h2c80c84b;

    // Settings and output count of one table row
    typedef struct packed {
        logic        en;
        logic [15:0] gain;
        logic [15:0] delay;
        logic [7:0]  n_out;
    } row_t;

    logic               a_clk;
    logic               rst_n;
    logic signed [15:0] sig_in;
    logic               sig_in_valid;
    logic               qc_enable;
    logic signed [15:0] qc_gain;
    logic [15:0]        qc_delay;
    logic signed [15:0] qc_out;
    logic               qc_out_valid;

    // Model history, one entry per tick
    logic signed [15:0] hist_sample [0:HIST_LEN-1];
    logic               hist_en     [0:HIST_LEN-1];
    logic signed [15:0] hist_gain   [0:HIST_LEN-1];
    logic [15:0]        hist_delay  [0:HIST_LEN-1];

    row_t        rows [0:NUM_ROWS-1];
    logic [31:0] lcg_state;
    int          cycle_idx   = 0;
    int          tick_count  = 0;
    int          out_count   = 0;
    int          check_count = 0;
    int          err_count   = 0;
    bit          timed_out   = 1'b0;

    tb_clock_gen u_tb_clock_gen (
        .a_clk (a_clk),
        .rst_n (rst_n)
    );

    qcontrol_top u_qcontrol_top (
        .a_clk        (a_clk),
        .rst_n        (rst_n),
        .sig_in       (sig_in),
        .sig_in_valid (sig_in_valid),
        .qc_enable    (qc_enable),
        .qc_gain      (qc_gain),
        .qc_delay     (qc_delay),
        .qc_out       (qc_out),
        .qc_out_valid (qc_out_valid)
    );

    ////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic row_t make_row(input logic en, input logic [15:0] gain,
                                      input logic [15:0] delay, input logic [7:0] n_out);
        return {en, gain, delay, n_out};
    endfunction

    // Gain times sample, scaled by 2^-13, kept as 15 bits and sign-extended
    function automatic logic signed [15:0] expected_out(input logic en,
                                                        input logic signed [15:0] gain,
                                                        input logic signed [15:0] sample);
        longint      prod;
        longint      scaled;
        logic [14:0] field;
        if (!en)
        begin
            return '0;
        end
        prod   = longint'(gain) * longint'(sample);
        scaled = prod >>> `QC_OUT_SHIFT;
        field  = scaled[14:0];
        return {field[14], field};
    endfunction

    ////////////////////////////////////////
    // Stimulus and tick logging
    ////////////////////////////////////////

    // New random sample every cycle, 5 ns after the edge
    initial
    begin
        lcg_state    = SEED;
        sig_in       = '0;
        sig_in_valid = 1'b0;
        forever
        begin
            @(posedge a_clk);
            if (rst_n)
            begin
                cycle_idx = cycle_idx + 1;
            end
            #5;
            lcg_state    = lcg_next(lcg_state);
            sig_in       = lcg_state[31:16];
            sig_in_valid = lcg_state[15];
        end
    end

    // Inputs are stable at the falling edge
    // Last cycle of each group of QC_DECIM is a tick
    always @(negedge a_clk)
    begin
        if (rst_n === 1'b1 && cycle_idx % `QC_DECIM == `QC_DECIM - 1 && tick_count < HIST_LEN)
        begin
            hist_sample[tick_count] = sig_in;
            hist_en[tick_count]     = qc_enable;
            hist_gain[tick_count]   = qc_gain;
            hist_delay[tick_count]  = qc_delay;
            tick_count              = tick_count + 1;
        end
    end

    ////////////////////////////////////////
    // Output checking
    ////////////////////////////////////////

    task automatic wait_pulse(output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < PULSE_WAIT)
        begin
            @(negedge a_clk);
            n = n + 1;
            if (qc_out_valid === 1'b1)
            begin
                seen = 1'b1;
            end
        end
        if (!seen)
        begin
            $display("Timed out after %0d cycles waiting for qc_out_valid pulse %0d",
                     PULSE_WAIT, out_count);
            timed_out = 1'b1;
        end
    endtask

    // Output k belongs to tick k, settings from tick k-1
    task automatic take_pulse(input bit compare, inout int row_errs);
        bit                 seen;
        int                 k;
        int                 dly;
        int                 lag;
        int                 want_cycle;
        logic signed [15:0] exp_val;
        wait_pulse(seen);
        if (seen)
        begin
            k          = out_count;
            out_count  = out_count + 1;
            // Three cycles after the tick cycle
            want_cycle = `QC_DECIM * k + `QC_DECIM - 1 + 3;
            if (cycle_idx != want_cycle)
            begin
                $display("qc_out_valid pulse %0d came in cycle %0d instead of cycle %0d",
                         k, cycle_idx, want_cycle);
                err_count = err_count + 1;
                row_errs  = row_errs + 1;
            end
            if (compare && k >= 1 && k < HIST_LEN)
            begin
                // Delay 0 reaches back a full memory depth
                dly = hist_delay[k-1] % DEPTH;
                lag = (dly == 0) ? DEPTH : DEPTH - dly;
                if (k - lag >= 0)
                begin
                    exp_val     = expected_out(hist_en[k-1], hist_gain[k-1], hist_sample[k-lag]);
                    check_count = check_count + 1;
                    if (qc_out !== exp_val)
                    begin
                        $display("** Error at time %0t: qc_out expected %h, actual %h (tick %0d)",
                                 $time, exp_val, qc_out, k);
                        err_count = err_count + 1;
                        row_errs  = row_errs + 1;
                    end
                end
            end
        end
    endtask

    task automatic apply_row(input row_t r);
        @(posedge a_clk);
        #5;
        qc_enable = r.en;
        qc_gain   = r.gain;
        qc_delay  = r.delay;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial
    begin
        int n;
        int row_errs;
        int checked_before;
        // Fill settings, unity gain at full depth
        qc_enable = 1'b1;
        qc_gain   = 16'sh2000;
        qc_delay  = '0;

        // Enable low, then unity gain at each delay, then odd gains
        rows[0]  = make_row(1'b0, 16'h2000, 16'd0,    8'd16);
        rows[1]  = make_row(1'b1, 16'h2000, 16'd0,    8'd16);
        rows[2]  = make_row(1'b1, 16'h2000, 16'd1,    8'd16);
        rows[3]  = make_row(1'b1, 16'h2000, 16'd100,  8'd16);
        rows[4]  = make_row(1'b1, 16'h2000, 16'd4095, 8'd16);
        rows[5]  = make_row(1'b1, 16'h2000, 16'd8191, 8'd16);
        rows[6]  = make_row(1'b1, 16'he000, 16'd100,  8'd16);
        rows[7]  = make_row(1'b1, 16'h7fff, 16'd4095, 8'd16);
        rows[8]  = make_row(1'b1, 16'h8000, 16'd1,    8'd16);
        rows[9]  = make_row(1'b1, 16'h5a5a, 16'd2048, 8'd16);
        rows[10] = make_row(1'b0, 16'h8000, 16'd8191, 8'd16);

        n = 0;
        while (rst_n !== 1'b1 && n < RESET_WAIT)
        begin
            @(posedge a_clk);
            n = n + 1;
        end
        if (rst_n !== 1'b1)
        begin
            $display("Timed out waiting for rst_n to be released");
            timed_out = 1'b1;
        end

        // Memory fill, timing checked but values not yet meaningful
        row_errs = 0;
        while (!timed_out && out_count < DEPTH)
        begin
            take_pulse(1'b0, row_errs);
        end

        for (int i = 0; i < NUM_ROWS && !timed_out; i++)
        begin
            row_errs       = 0;
            checked_before = check_count;
            apply_row(rows[i]);
            // Outputs still on the old settings
            for (int j = 0; j < 2 && !timed_out; j++)
            begin
                take_pulse(1'b0, row_errs);
            end
            for (int j = 0; j < rows[i].n_out && !timed_out; j++)
            begin
                take_pulse(1'b1, row_errs);
            end
            $display("Row %0d: enable %0b gain %h delay %0d, %0d outputs checked, %0d errors",
                     i, rows[i].en, rows[i].gain, rows[i].delay,
                     check_count - checked_before, row_errs);
        end

        // One pulse per tick so far
        if (!timed_out && out_count != tick_count)
        begin
            $display("Saw %0d qc_out_valid pulses for %0d ticks", out_count, tick_count);
            err_count = err_count + 1;
        end

        $display("Counts: %0d values checked, %0d pulses, %0d ticks, %0d errors",
                 check_count, out_count, tick_count, err_count);
        if (err_count == 0 && !timed_out)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
